//--- Bender.yml
package:
  name: ahbApbBridge

export_include_dirs:
  - logic

sources:
  - files:
      - logic/ahbApbPkg.sv
      - logic/ahbSlaveStage.sv
      - logic/apbControlStage.sv
      - logic/ahbApbBridge.sv
  - target: test
    files:
      - tests/apbMemModel.sv
      - tests/ahbApbTb.sv

//--- ahbApbBridge.f
+incdir+logic
logic/ahbApbPkg.sv
logic/ahbSlaveStage.sv
logic/apbControlStage.sv
logic/ahbApbBridge.sv
tests/apbMemModel.sv
tests/ahbApbTb.sv

//--- logic/ahbApbBridge.sv
// top level of the AHB-to-APB bridge
// AHB slave stage feeding the APB control FSM, read data returned unregistered

`timescale 1ns/1ps

`include "ahbApbParams.svh"

module ahbApbBridge (
	input logic Hclk,
	input logic Hresetn,
	input logic Hsel,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [31:0] Haddr,
	input logic [31:0] Hwdata,
	input logic [31:0] Prdata,
	output logic Hreadyout,
	output logic [31:0] Hrdata,
	output logic Hresp,
	output logic [31:0] Paddr,
	output logic [31:0] Pwdata,
	output logic Pwrite,
	output logic Penable,
	output logic [2:0] Pselx
);

	ahbApbPkg::ahbStageT stage;
	ahbApbPkg::apbAddrT paddrView;

	// only slave on the bus, so its own ready closes the loop
	ahbSlaveStage ahbSide (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hsel(Hsel),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyout),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.stage(stage)
	);

	apbControlStage apbSide (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.stage(stage),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Hreadyout(Hreadyout),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata)
	);

	assign Hrdata = Prdata;
	assign Hresp = 1'b0;  // always OKAY
	assign paddrView = Paddr;

	// the select has to match the region of the address it travels with
	selMatchesRegion: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Pselx != 3'b000) |->
		((Pselx[0] && (paddrView.fields.region == `REGION0_BASE))
		|| (Pselx[1] && (paddrView.fields.region == `REGION1_BASE))
		|| (Pselx[2] && (paddrView.fields.region == `REGION2_BASE))));

endmodule

//--- logic/ahbApbParams.svh
// region codes for the three APB peripheral windows
// AHB transfer-type codes that mark an active transfer

`ifndef AHB_APB_PARAMS_SVH
`define AHB_APB_PARAMS_SVH

// top address byte of each peripheral region
`define REGION0_BASE 8'h80
`define REGION1_BASE 8'h84
`define REGION2_BASE 8'h88

// IDLE and BUSY are ignored by the bridge
`define HTRANS_NONSEQ 2'b10
`define HTRANS_SEQ 2'b11

`endif

//--- logic/ahbApbPkg.sv
// types shared by the bridge stages
// address union, AHB stage bundle and APB controller state encoding

package ahbApbPkg;

	typedef struct packed {
		logic [7:0] region;  // top byte selects the peripheral
		logic [23:0] offset;
	} addrFieldsT;

	typedef union packed {
		logic [31:0] word;
		addrFieldsT fields;
	} apbAddrT;

	typedef struct packed {
		logic valid;  // accepted transfer aimed at a known region
		logic write;
		logic writeReg;  // Hwrite of the last accepted address phase
		apbAddrT addr;
		apbAddrT addr1;
		apbAddrT addr2;
		logic [31:0] wdata;
		logic [2:0] sel;
	} ahbStageT;

	typedef enum logic [2:0] {
		stIdle = 3'b000,
		stWwait = 3'b001,
		stRead = 3'b010,
		stWrite = 3'b011,
		stWritep = 3'b100,
		stRenable = 3'b101,
		stWenable = 3'b110,
		stWenablep = 3'b111
	} apbStateT;

endpackage

//--- logic/ahbSlaveStage.sv
// AHB-facing stage of the bridge
// qualifies the address phase, decodes the region and keeps the delayed address copies

`timescale 1ns/1ps

`include "ahbApbParams.svh"

module ahbSlaveStage (
	input logic Hclk,
	input logic Hresetn,
	input logic Hsel,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic Hreadyin,
	input logic [31:0] Haddr,
	input logic [31:0] Hwdata,
	output ahbApbPkg::ahbStageT stage
);

	ahbApbPkg::apbAddrT liveAddr;
	ahbApbPkg::apbAddrT addr1;
	ahbApbPkg::apbAddrT addr2;
	logic writeReg;
	logic active;
	logic [2:0] sel;

	assign liveAddr = Haddr;
	assign active = (Htrans == `HTRANS_NONSEQ) || (Htrans == `HTRANS_SEQ);

	always_comb
	begin
		case (liveAddr.fields.region)
			`REGION0_BASE: sel = 3'b001;
			`REGION1_BASE: sel = 3'b010;
			`REGION2_BASE: sel = 3'b100;
			default: sel = 3'b000;  // outside every window
		endcase
	end

	// addr1 holds the last accepted address while the master is stalled
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
			addr1 <= liveAddr;
		addr2 <= addr1;  // trails addr1 by one clock for the back-to-back setup
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			writeReg <= 1'b0;
		else if (Hreadyin)
			writeReg <= Hwrite;
	end

	always_comb
	begin
		stage.valid = Hsel && Hreadyin && active && (sel != 3'b000);
		stage.write = Hwrite;
		stage.writeReg = writeReg;
		stage.addr = liveAddr;
		stage.addr1 = addr1;
		stage.addr2 = addr2;
		stage.wdata = Hwdata;
		stage.sel = sel;
	end

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(stage.sel));

endmodule

//--- logic/apbControlStage.sv
// APB sequencing FSM of the bridge
// drives the APB setup and enable phases and stalls the AHB master through Hreadyout

`timescale 1ns/1ps

module apbControlStage (
	input logic Hclk,
	input logic Hresetn,
	input ahbApbPkg::ahbStageT stage,
	output logic Pwrite,
	output logic Penable,
	output logic Hreadyout,
	output logic [2:0] Pselx,
	output logic [31:0] Paddr,
	output logic [31:0] Pwdata
);

	ahbApbPkg::apbStateT state;
	ahbApbPkg::apbStateT nextState;
	logic [2:0] pendSel;
	logic pwriteNext;
	logic penableNext;
	logic hreadyNext;
	logic [2:0] pselNext;
	logic [31:0] paddrNext;
	logic [31:0] pwdataNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= ahbApbPkg::stIdle;
		else
			state <= nextState;
	end

	// select of the most recently accepted transfer, used when its setup comes later
	always_ff @(posedge Hclk)
	begin
		if (stage.valid)
			pendSel <= stage.sel;
	end

	always_comb
	begin
		case (state)
			ahbApbPkg::stIdle, ahbApbPkg::stRenable, ahbApbPkg::stWenable:
			begin
				if (!stage.valid)
					nextState = ahbApbPkg::stIdle;
				else if (stage.write)
					nextState = ahbApbPkg::stWwait;
				else
					nextState = ahbApbPkg::stRead;
			end
			ahbApbPkg::stWwait:
			begin
				if (stage.valid)
					nextState = ahbApbPkg::stWritep;
				else
					nextState = ahbApbPkg::stWrite;
			end
			ahbApbPkg::stRead:
				nextState = ahbApbPkg::stRenable;
			ahbApbPkg::stWrite:
			begin
				if (stage.valid)
					nextState = ahbApbPkg::stWenablep;
				else
					nextState = ahbApbPkg::stWenable;
			end
			ahbApbPkg::stWritep:
				nextState = ahbApbPkg::stWenablep;
			ahbApbPkg::stWenablep:
			begin
				if (!stage.writeReg)
					nextState = ahbApbPkg::stRead;
				else if (stage.valid)
					nextState = ahbApbPkg::stWritep;
				else
					nextState = ahbApbPkg::stWrite;
			end
			default:
				nextState = ahbApbPkg::stIdle;
		endcase
	end

	always_comb
	begin
		pwriteNext = Pwrite;
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		pselNext = 3'b000;
		penableNext = 1'b0;
		hreadyNext = 1'b1;
		case (state)
			ahbApbPkg::stIdle, ahbApbPkg::stRenable, ahbApbPkg::stWenable:
			begin
				if (stage.valid && !stage.write)
				begin
					paddrNext = stage.addr.word;  // reads go straight to setup
					pwriteNext = 1'b0;
					pselNext = stage.sel;
					hreadyNext = 1'b0;
				end
			end
			ahbApbPkg::stWwait:
			begin
				paddrNext = stage.addr1.word;
				pwriteNext = 1'b1;
				pselNext = pendSel;
				pwdataNext = stage.wdata;  // write data phase completes this cycle
				hreadyNext = 1'b0;
			end
			ahbApbPkg::stRead, ahbApbPkg::stWrite:
			begin
				pselNext = Pselx;
				penableNext = 1'b1;
			end
			ahbApbPkg::stWritep:
			begin
				pselNext = Pselx;
				penableNext = 1'b1;
				hreadyNext = stage.writeReg;  // a pending read keeps the master waiting for its data
			end
			ahbApbPkg::stWenablep:
			begin
				paddrNext = stage.addr2.word;
				pwriteNext = stage.writeReg;
				pselNext = pendSel;
				hreadyNext = 1'b0;
				if (stage.writeReg)
					pwdataNext = stage.wdata;
			end
			default:
			begin
				pselNext = 3'b000;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pwrite <= 1'b0;
			Penable <= 1'b0;
			Pselx <= 3'b000;
			Paddr <= 32'h0;
			Pwdata <= 32'h0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Pwrite <= pwriteNext;
			Penable <= penableNext;
			Pselx <= pselNext;
			Paddr <= paddrNext;
			Pwdata <= pwdataNext;
			Hreadyout <= hreadyNext;
		end
	end

	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != 3'b000));

	selxOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(Pselx));

	readThenEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == ahbApbPkg::stRead) |=> ((state == ahbApbPkg::stRenable) && Penable
		&& !Pwrite && Hreadyout));

endmodule

//--- tests/ahbApbTb.sv
// testbench for the AHB-to-APB bridge
// AHB master driver, random stimulus, shadow memory and APB transfer checks

`timescale 1ns/1ps

`include "ahbApbParams.svh"

module ahbApbTb;

	typedef struct packed {
		logic valid;
		logic write;
		logic [31:0] addr;
		logic [31:0] data;
	} xferT;

	logic Hclk, Hresetn, Hsel, Hwrite, Hreadyout, Hresp, Pwrite, Penable;
	logic [1:0] Htrans;
	logic [2:0] Pselx, setupSel;
	logic [31:0] Haddr, Hwdata, Hrdata, Prdata, Paddr, Pwdata, pick, wdata;
	logic [7:0] region;
	logic [191:0] touched;
	logic [31:0] shadow [0:191];
	logic timedOut, setupSeen;
	integer writeCount, seed, errors, checks, expWrites, gap, i;
	xferT dataPhase, setup, expected;
	xferT expQ [$];  // in-region transfers waiting for their APB enable phase

	ahbApbBridge UUT (.*);
	apbMemModel apbMem (.*);

	initial
	begin
		Hclk = 1'b0;
		forever #10 Hclk = ~Hclk;
	end

	task automatic reportError(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	function automatic logic [2:0] regionSel(input logic [31:0] addr);
		case (addr[31:24])
			`REGION0_BASE: regionSel = 3'b001;
			`REGION1_BASE: regionSel = 3'b010;
			`REGION2_BASE: regionSel = 3'b100;
			default: regionSel = 3'b000;
		endcase
	endfunction

	function automatic integer shadowIndex(input logic [31:0] addr);
		logic [2:0] sel;
		sel = regionSel(addr);
		shadowIndex = (sel[2] ? 128 : (sel[1] ? 64 : 0)) + addr[7:2];
	endfunction

	// a word never written still holds the model's fill
	function automatic logic [31:0] expectedWord(input logic [31:0] addr);
		integer idx;
		idx = shadowIndex(addr);
		expectedWord = touched[idx] ? shadow[idx] : (addr ^ 32'h3c5a_96e1);
	endfunction

	// holds one address phase until accepted and retires the previous data phase with it
	task automatic busCycle(input xferT addrPhase);
		integer stalls;
		integer idx;
		logic accepted;
		stalls = 0;
		accepted = 1'b0;
		Hsel = addrPhase.valid;
		Htrans = addrPhase.valid ? `HTRANS_NONSEQ : 2'b00;
		Haddr = addrPhase.addr;
		Hwrite = addrPhase.write;
		Hwdata = dataPhase.data;
		while (!accepted && !timedOut)
		begin
			@(negedge Hclk);
			if (Hreadyout)
			begin
				accepted = 1'b1;
				checks++;
				if (Hresp !== 1'b0)
					reportError($sformatf("Hresp is %b, expected OKAY", Hresp));
				idx = shadowIndex(dataPhase.addr);
				if (dataPhase.valid && (regionSel(dataPhase.addr) != 3'b000))
				begin
					checks++;
					if (dataPhase.write)
					begin
						shadow[idx] = dataPhase.data;
						touched[idx] = 1'b1;
						expWrites++;
					end
					else if (Hrdata !== expectedWord(dataPhase.addr))
						reportError($sformatf("read of %h gave %h, expected %h", dataPhase.addr,
							Hrdata, expectedWord(dataPhase.addr)));
				end
				if (addrPhase.valid && (regionSel(addrPhase.addr) != 3'b000))
					expQ.push_back(addrPhase);
				dataPhase = addrPhase;
			end
			else
			begin
				stalls++;
				if (stalls > 8)
				begin
					$display("Timeout: Hreadyout stayed low for more than 8 cycles at %0t ns", $time);
					timedOut = 1'b1;
				end
			end
			@(posedge Hclk);
			#2;
		end
	endtask

	always @(negedge Hclk)
	begin
		if (Hresetn && (Pselx != 3'b000) && !Penable)
		begin
			checks++;
			if (setupSeen || (Pselx !== regionSel(Paddr)))
				reportError($sformatf("bad setup phase, Pselx %b for Paddr %h", Pselx, Paddr));
			setup = {1'b1, Pwrite, Paddr, Pwdata};
			setupSel = Pselx;
			setupSeen = 1'b1;
		end
		else if (Hresetn && Penable)
		begin
			checks++;
			if (!setupSeen || (Paddr !== setup.addr) || (Pwrite !== setup.write)
				|| (Pselx !== setupSel))
				reportError($sformatf("enable phase at %h differs from its setup phase", Paddr));
			else if (expQ.size() == 0)
				reportError($sformatf("unexpected APB transfer to %h", Paddr));
			else
			begin
				expected = expQ.pop_front();  // APB transfers must come out in AHB order
				if ((Paddr !== expected.addr) || (Pwrite !== expected.write)
					|| (Pwrite && (Pwdata !== expected.data)))
					reportError($sformatf("APB saw %h w%b %h, expected %h w%b %h", Paddr, Pwrite,
						Pwdata, expected.addr, expected.write, expected.data));
			end
			setupSeen = 1'b0;
		end
		else if (Hresetn && setupSeen)
		begin
			reportError("setup phase not followed by an enable phase");
			setupSeen = 1'b0;
		end
	end

	initial
	begin
		seed = 32'h6bb3;
		errors = 0;
		checks = 0;
		expWrites = 0;
		timedOut = 1'b0;
		setupSeen = 1'b0;
		touched = '0;
		dataPhase = '0;
		Hresetn = 1'b0;
		Hsel = 1'b0;
		Htrans = 2'b00;
		Hwrite = 1'b0;
		Haddr = 32'h0;
		Hwdata = 32'h0;
		repeat (4) @(posedge Hclk);
		#2;
		Hresetn = 1'b1;
		@(negedge Hclk);
		checks++;
		if ((Pselx !== 3'b000) || (Penable !== 1'b0) || (Pwrite !== 1'b0))
			reportError("APB outputs not idle after reset");
		i = 1;
		while ((Hreadyout !== 1'b1) && (i < 2))
		begin
			@(negedge Hclk);
			i++;
		end
		checks++;
		if (Hreadyout !== 1'b1)
			reportError("Hreadyout not high by the second cycle after reset");
		@(posedge Hclk);
		#2;
		busCycle({1'b1, 1'b0, 32'h8000_0010, 32'h0});  // untouched word returns the fill
		busCycle({1'b1, 1'b1, 32'h8400_0020, 32'hcafe_0001});
		busCycle({1'b1, 1'b1, 32'h8400_0024, 32'hcafe_0002});
		busCycle({1'b1, 1'b0, 32'h8400_0020, 32'h0});  // runs through stWritep and stWenablep
		busCycle({1'b1, 1'b1, 32'h9000_0040, 32'hdead_0003});
		busCycle({1'b1, 1'b0, 32'h8800_0030, 32'h0});
		for (i = 0; i < 200; i++)
		begin
			pick = $random(seed);
			wdata = $random(seed);
			gap = pick[9:8] % 3;
			repeat (gap) busCycle('0);
			if (pick[2:0] == 3'd7)
				region = {4'h9, pick[15:12]};  // outside every window
			else if (pick[1:0] == 2'd0)
				region = `REGION0_BASE;
			else if (pick[1:0] == 2'd1)
				region = `REGION1_BASE;
			else
				region = `REGION2_BASE;
			busCycle({1'b1, pick[3], region, 16'h0, pick[21:16], 2'b00, wdata});
		end
		busCycle('0);
		i = 0;
		while (((expQ.size() != 0) || (Pselx != 3'b000)) && (i < 20))
		begin
			@(negedge Hclk);
			i++;
		end
		if ((expQ.size() != 0) || (Pselx != 3'b000))
		begin
			$display("APB transfers still pending at the end of the run");
			timedOut = 1'b1;
		end
		checks++;
		if (writeCount !== expWrites)
			reportError($sformatf("memory saw %0d writes, expected %0d", writeCount, expWrites));
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timedOut);
		if ((errors == 0) && !timedOut)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tests/apbMemModel.sv
// APB memory model with three regions of 64 words each
// answers reads combinationally and counts completed writes

`timescale 1ns/1ps

`include "ahbApbParams.svh"

module apbMemModel (
	input logic Hclk,
	input logic [2:0] Pselx,
	input logic Penable,
	input logic Pwrite,
	input logic [31:0] Paddr,
	input logic [31:0] Pwdata,
	output logic [31:0] Prdata,
	output integer writeCount
);

	logic [31:0] mem [0:191];
	logic [7:0] index;
	integer i;

	// region comes from the select, the word from the low offset bits
	assign index = (Pselx[2] ? 8'd128 : (Pselx[1] ? 8'd64 : 8'd0)) + {2'b00, Paddr[7:2]};
	assign Prdata = ((Pselx != 3'b000) && !Pwrite) ? mem[index] : 32'h0;

	initial
	begin
		writeCount = 0;
		for (i = 0; i < 192; i++)
			mem[i] = {((i < 64) ? `REGION0_BASE : ((i < 128) ? `REGION1_BASE : `REGION2_BASE)),
				16'h0, i[5:0], 2'b00} ^ 32'h3c5a_96e1;  // fill is the full address XOR a constant
	end

	always @(posedge Hclk)
	begin
		if ((Pselx != 3'b000) && Penable && Pwrite)
		begin
			mem[index] <= Pwdata;
			writeCount <= writeCount + 1;
		end
	end

endmodule
